//--- common/fir_cfg_pkg.sv
`default_nettype none

package fir_cfg_pkg;

    // Sample and weight width, fixed
    localparam int DATA_WIDTH = 16;

    // Log2 of the deepest filter the accumulator is sized for
    localparam int MAX_DEPTH_LOG = 4;

    // Full product plus growth over all taps
    localparam int ACC_WIDTH = 2 * DATA_WIDTH + MAX_DEPTH_LOG;

    // One input sample, also one weight
    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    // Partial sum of a segment, and the filter output
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // Hex weights, one per line, tap 0 first
    localparam string WEIGHT_FILE = "weights.mem";

endpackage

`default_nettype wire

//--- common/fir_ctrl_pkg.sv
`default_nettype none

package fir_ctrl_pkg;

    // Sequencer states, one sample in flight
    typedef enum logic [2:0] {
        IDLE         = 3'd0, // Waiting for i_din_valid
        FETCH_OLDEST = 3'd1, // Read oldest slot for the hand-off
        WRITE_SAMPLE = 3'd2, // Accept sample, write every segment
        PRIME_READ   = 3'd3, // First read, covers memory latency
        MAC          = 3'd4, // SEG_DEPTH multiply-accumulate cycles
        HOLD_OUTPUT  = 3'd5  // Wait until the output is taken
    } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/fir_sequencer.sv
`default_nettype none

module fir_sequencer
    import fir_cfg_pkg::*;
    import fir_ctrl_pkg::*;
#(
    parameter int FIR_DEPTH    = 16,
    parameter int NUM_SEGMENTS = 1,
    localparam int SEG_DEPTH   = FIR_DEPTH / NUM_SEGMENTS,
    localparam int ADDR_W      = (SEG_DEPTH > 1) ? $clog2(SEG_DEPTH) : 1
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_din_valid,
    input  wire logic              i_out_done,   // Output handshake completed
    output logic                   o_ready,
    output logic                   o_sample_re,
    output logic                   o_sample_we,
    output logic [ADDR_W-1:0]      o_sample_addr,
    output logic                   o_weight_re,
    output logic [ADDR_W-1:0]      o_weight_addr,
    output logic                   o_mac_en,
    output logic                   o_acc_clr,
    output logic                   o_capture     // Last MAC cycle
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(SEG_DEPTH - 1);

    seq_state_t state;
    seq_state_t state_next;

    logic [ADDR_W-1:0] wr_ptr;  // Slot of the oldest sample, next write
    logic [ADDR_W-1:0] rd_ptr;  // Next history read during MAC
    logic [ADDR_W-1:0] wt_addr; // Saturates at LAST_ADDR
    logic [ADDR_W-1:0] mac_cnt; // MAC cycles done
    logic              mac_last;

    // Accumulator growth only covers 2**MAX_DEPTH_LOG taps
    if (FIR_DEPTH > 2 ** MAX_DEPTH_LOG || FIR_DEPTH % NUM_SEGMENTS != 0) begin : g_bad_cfg
        $error("fir_sequencer: unsupported FIR_DEPTH / NUM_SEGMENTS");
    end

    function automatic logic [ADDR_W-1:0] wrap_inc(input logic [ADDR_W-1:0] addr);
        if (addr == LAST_ADDR) begin
            return '0;
        end
        return addr + 1'b1;
    endfunction

    assign mac_last = (state == MAC) && (mac_cnt == LAST_ADDR);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:         if (i_din_valid) state_next = FETCH_OLDEST;
            FETCH_OLDEST: state_next = WRITE_SAMPLE;
            WRITE_SAMPLE: state_next = PRIME_READ;
            PRIME_READ:   state_next = MAC;
            MAC:          if (mac_last) state_next = HOLD_OUTPUT;
            HOLD_OUTPUT:  if (i_out_done) state_next = IDLE; // Back-pressure parks here
            default:      state_next = IDLE;
        endcase
    end

    // Pointers and counters
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            wt_addr <= '0;
            mac_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    wt_addr <= '0;
                    mac_cnt <= '0;
                end
                PRIME_READ: begin
                    rd_ptr <= wrap_inc(wr_ptr);          // One step older than newest
                    wr_ptr <= (wr_ptr == '0) ? LAST_ADDR : wr_ptr - 1'b1;
                    if (wt_addr != LAST_ADDR) wt_addr <= wt_addr + 1'b1;
                end
                MAC: begin
                    rd_ptr  <= wrap_inc(rd_ptr);
                    mac_cnt <= mac_cnt + 1'b1;
                    if (wt_addr != LAST_ADDR) wt_addr <= wt_addr + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Decoded strobes
    assign o_ready       = (state == WRITE_SAMPLE);
    assign o_sample_we   = (state == WRITE_SAMPLE); // Same slot as the fetch
    assign o_sample_re   = (state == FETCH_OLDEST) || (state == PRIME_READ) ||
                           ((state == MAC) && !mac_last);
    assign o_weight_re   = (state == PRIME_READ) || ((state == MAC) && !mac_last);
    assign o_sample_addr = (state == MAC) ? rd_ptr : wr_ptr;
    assign o_weight_addr = wt_addr;
    assign o_mac_en      = (state == MAC);
    assign o_acc_clr     = (state == IDLE);
    assign o_capture     = mac_last;

    // Ready is a single pulse on the slot that was just fetched
    ap_ready_slot: assert property (@(posedge i_clk) disable iff (i_rst)
        o_ready |-> $past(o_sample_re) && !$past(o_ready) &&
                    (o_sample_addr == $past(o_sample_addr)));

    // Weight read runs one tap ahead of the MAC count
    ap_weight_step: assert property (@(posedge i_clk) disable iff (i_rst)
        o_weight_re |-> (o_weight_addr == (o_mac_en ? mac_cnt + 1'b1 : '0)));

endmodule

`default_nettype wire

//--- fir_segment/fir_segment.sv
`default_nettype none

module fir_segment
    import fir_cfg_pkg::*;
#(
    parameter int FIR_DEPTH    = 16,
    parameter int NUM_SEGMENTS = 1,
    parameter int SEG_INDEX    = 0,
    localparam int SEG_DEPTH   = FIR_DEPTH / NUM_SEGMENTS,
    localparam int ADDR_W      = (SEG_DEPTH > 1) ? $clog2(SEG_DEPTH) : 1
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire sample_t           i_sample_in,   // i_din or previous hand-off
    input  wire logic              i_sample_re,
    input  wire logic              i_sample_we,
    input  wire logic [ADDR_W-1:0] i_sample_addr,
    input  wire logic              i_weight_re,
    input  wire logic [ADDR_W-1:0] i_weight_addr,
    input  wire logic              i_mac_en,
    input  wire logic              i_acc_clr,
    output sample_t                o_sample_out,  // Displaced oldest sample
    output acc_t                   o_partial_sum
);

    localparam int WEIGHT_BASE = SEG_INDEX * SEG_DEPTH; // First tap of this segment

    sample_t hist_mem [SEG_DEPTH] = '{default: '0}; // Empty history at power-up
    sample_t weight_mem [FIR_DEPTH];

    sample_t sample_rd;
    sample_t weight_rd;
    logic signed [2*DATA_WIDTH-1:0] product;
    acc_t acc;

    initial begin
        $readmemh(WEIGHT_FILE, weight_mem); // Whole file, only this slice is read
    end

    // History RAM, read-first single port
    always_ff @(posedge i_clk) begin
        if (i_sample_re) begin
            sample_rd <= hist_mem[i_sample_addr];
        end
        if (i_sample_we) begin
            hist_mem[i_sample_addr] <= i_sample_in;
        end
    end

    // Weight ROM
    always_ff @(posedge i_clk) begin
        if (i_weight_re) begin
            weight_rd <= weight_mem[WEIGHT_BASE + int'(i_weight_addr)];
        end
    end

    assign product = sample_rd * weight_rd; // Full 32-bit product

    always_ff @(posedge i_clk) begin
        if (i_rst || i_acc_clr) begin
            acc <= '0;
        end else if (i_mac_en) begin
            acc <= acc + product; // Sign-extended to ACC_WIDTH
        end
    end

    // Read data from FETCH_OLDEST, stable through WRITE_SAMPLE
    assign o_sample_out  = sample_rd;
    assign o_partial_sum = acc;

    // A write in MAC would corrupt the history walk
    ap_no_we_in_mac: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_sample_we && i_mac_en));

endmodule

`default_nettype wire

//--- rtl/fir_output_stage.sv
`default_nettype none

module fir_output_stage
    import fir_cfg_pkg::*;
#(
    parameter int NUM_SEGMENTS = 1
) (
    input  wire logic i_clk,
    input  wire logic i_rst,
    input  wire acc_t i_partial_sums [NUM_SEGMENTS],
    input  wire logic i_capture,   // Last MAC cycle of the sequencer
    input  wire logic i_ready,
    output acc_t      o_dout,
    output logic      o_dout_valid,
    output logic      o_done       // Handshake completes this edge
);

    acc_t total;
    logic capture_d; // Partial sums settle one cycle after the strobe

    always_comb begin
        total = '0;
        for (int k = 0; k < NUM_SEGMENTS; k++) begin
            total = total + i_partial_sums[k];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            capture_d    <= 1'b0;
            o_dout_valid <= 1'b0;
        end else begin
            capture_d <= i_capture;
            if (capture_d) begin
                o_dout_valid <= 1'b1;
            end else if (o_done) begin
                o_dout_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture_d) begin
            o_dout <= total; // Held until taken
        end
    end

    assign o_done = o_dout_valid && i_ready;

    // Output must not move while the receiver stalls
    ap_dout_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_dout_valid && !i_ready) |=> $stable(o_dout) && o_dout_valid);

endmodule

`default_nettype wire

//--- rtl/fir_filter.sv
`default_nettype none

module fir_filter
    import fir_cfg_pkg::*;
#(
    parameter int FIR_DEPTH    = 16,
    parameter int NUM_SEGMENTS = 1
) (
    input  wire logic    i_clk,
    input  wire logic    i_rst,
    input  wire sample_t i_din,
    input  wire logic    i_din_valid,
    input  wire logic    i_ready,
    output logic         o_ready,
    output acc_t         o_dout,
    output logic         o_dout_valid
);

    localparam int SEG_DEPTH = FIR_DEPTH / NUM_SEGMENTS;
    localparam int ADDR_W    = (SEG_DEPTH > 1) ? $clog2(SEG_DEPTH) : 1;

    logic              sample_re;
    logic              sample_we;
    logic [ADDR_W-1:0] sample_addr; // Shared by all segments
    logic              weight_re;
    logic [ADDR_W-1:0] weight_addr;
    logic              mac_en;
    logic              acc_clr;
    logic              capture;
    logic              out_done;

    sample_t seg_out [NUM_SEGMENTS];      // Delay-line hand-off
    acc_t    partial_sums [NUM_SEGMENTS];

    fir_sequencer #(
        .FIR_DEPTH    (FIR_DEPTH),
        .NUM_SEGMENTS (NUM_SEGMENTS)
    ) u_fir_sequencer (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_din_valid   (i_din_valid),
        .i_out_done    (out_done),
        .o_ready       (o_ready),
        .o_sample_re   (sample_re),
        .o_sample_we   (sample_we),
        .o_sample_addr (sample_addr),
        .o_weight_re   (weight_re),
        .o_weight_addr (weight_addr),
        .o_mac_en      (mac_en),
        .o_acc_clr     (acc_clr),
        .o_capture     (capture)
    );

    for (genvar g = 0; g < NUM_SEGMENTS; g++) begin : g_seg
        sample_t seg_in;

        if (g == 0) begin : g_head
            assign seg_in = i_din;          // New sample enters here
        end else begin : g_link
            assign seg_in = seg_out[g-1];   // Oldest of the previous segment
        end

        fir_segment #(
            .FIR_DEPTH    (FIR_DEPTH),
            .NUM_SEGMENTS (NUM_SEGMENTS),
            .SEG_INDEX    (g)
        ) u_fir_segment (
            .i_clk         (i_clk),
            .i_rst         (i_rst),
            .i_sample_in   (seg_in),
            .i_sample_re   (sample_re),
            .i_sample_we   (sample_we),
            .i_sample_addr (sample_addr),
            .i_weight_re   (weight_re),
            .i_weight_addr (weight_addr),
            .i_mac_en      (mac_en),
            .i_acc_clr     (acc_clr),
            .o_sample_out  (seg_out[g]),
            .o_partial_sum (partial_sums[g])
        );
    end

    fir_output_stage #(
        .NUM_SEGMENTS (NUM_SEGMENTS)
    ) u_fir_output_stage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_partial_sums (partial_sums),
        .i_capture      (capture),
        .i_ready        (i_ready),
        .o_dout         (o_dout),
        .o_dout_valid   (o_dout_valid),
        .o_done         (out_done)
    );

endmodule

`default_nettype wire

//--- verification/tb_fir_filter.sv
`default_nettype none

module tb_fir_filter
    import fir_cfg_pkg::*;
();

    localparam int FIR_DEPTH    = 16;
    localparam int NUM_SEGMENTS = 2;   // Exercises the segment hand-off
    localparam int TIMEOUT      = 200; // Cycles per wait

    logic    i_clk;
    logic    i_rst;
    sample_t i_din;
    logic    i_din_valid;
    logic    i_ready;
    logic    o_ready;
    acc_t    o_dout;
    logic    o_dout_valid;

    sample_t weights [FIR_DEPTH];
    sample_t ref_hist [FIR_DEPTH] = '{default: '0}; // Matches DUT power-up history
    acc_t    exp_q [$];   // Expected outputs, oldest first
    int      accepted_cnt;
    int      output_cnt;
    int      seed;
    string   test_name;

    fir_filter #(
        .FIR_DEPTH    (FIR_DEPTH),
        .NUM_SEGMENTS (NUM_SEGMENTS)
    ) u_fir_filter (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_din        (i_din),
        .i_din_valid  (i_din_valid),
        .i_ready      (i_ready),
        .o_ready      (o_ready),
        .o_dout       (o_dout),
        .o_dout_valid (o_dout_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Newest sample pairs with weight 0
    function automatic acc_t ref_fir(input sample_t s);
        acc_t sum;
        sum = '0;
        for (int k = FIR_DEPTH - 1; k > 0; k--) begin
            ref_hist[k] = ref_hist[k-1];
        end
        ref_hist[0] = s;
        for (int k = 0; k < FIR_DEPTH; k++) begin
            sum = sum + acc_t'(ref_hist[k]) * acc_t'(weights[k]); // Exact, fits 36 bits
        end
        return sum;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_value(input string name, input acc_t exp, input acc_t act);
        if (exp !== act) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic wait_for_ready();
        int n;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_ready && n < TIMEOUT);
        if (!o_ready) fail_run("Timed out waiting for o_ready");
    endtask

    // o_ready must stay low while an output is pending
    task automatic wait_for_valid();
        int n;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
            if (o_ready) fail_run("o_ready went high before the output was taken");
        end while (!o_dout_valid && n < TIMEOUT);
        if (!o_dout_valid) fail_run("Timed out waiting for o_dout_valid");
    endtask

    // Entered and left 1 unit after a rising edge
    task automatic send_sample(input sample_t s, input acc_t exp, input int gap);
        repeat (gap) begin
            @(posedge i_clk);
            #1;
        end
        i_din       = s;
        i_din_valid = 1'b1;
        wait_for_ready();
        @(posedge i_clk);       // Accept edge
        exp_q.push_back(exp);
        accepted_cnt++;
        #1;
        i_din_valid = 1'b0;
        i_din       = '0;
    endtask

    task automatic take_output(input int stall);
        acc_t held;
        if (stall == 0) i_ready = 1'b1; // Receiver already waiting
        wait_for_valid();
        if (stall > 0) begin
            held = o_dout;
            for (int i = 0; i < stall; i++) begin
                @(negedge i_clk);
                check_value("held o_dout", held, o_dout);
                if (!o_dout_valid || o_ready) begin
                    fail_run("Handshake state changed under back-pressure");
                end
            end
            @(posedge i_clk);
            #1;
            i_ready = 1'b1;
        end
        @(posedge i_clk);       // Output handshake edge
        #1;
        i_ready = 1'b0;
    endtask

    task automatic run_one(input sample_t s, input acc_t exp, input int gap, input int stall);
        send_sample(s, exp, gap);
        take_output(stall);
    endtask

    // Compare at the falling edge, one hit per completed handshake
    always @(negedge i_clk) begin
        if (!i_rst && o_dout_valid && i_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("An output appeared with no accepted sample behind it");
            end else begin
                check_value(test_name, exp_q.pop_front(), o_dout);
                output_cnt++;
            end
        end
    end

    initial begin
        sample_t s;
        sample_t next_s;
        int      gap;
        int      stall;
        i_rst        = 1'b1;
        i_din        = '0;
        i_din_valid  = 1'b0;
        i_ready      = 1'b0;
        accepted_cnt = 0;
        output_cnt   = 0;
        seed         = 64;
        test_name    = "reset state";
        $readmemh("weights.mem", weights);

        repeat (2) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        repeat (4) begin
            @(negedge i_clk);
            check_value("reset o_ready", '0, acc_t'(o_ready));
            check_value("reset o_dout_valid", '0, acc_t'(o_dout_valid));
        end
        @(posedge i_clk);
        #1;

        // Unit impulse walks the taps out in file order
        test_name = "impulse response";
        for (int k = 0; k < FIR_DEPTH; k++) begin
            s = (k == 0) ? sample_t'(1) : sample_t'(0);
            void'(ref_fir(s));  // Keep model history in step
            run_one(s, acc_t'(weights[k]), 0, 0);
        end

        test_name = "random stream";
        for (int k = 0; k < 40; k++) begin
            if (k < 4) begin
                s = 16'sh8000;  // Most negative, worst-case growth
            end else if (k < 6) begin
                s = 16'sh7FFF;
            end else begin
                s = sample_t'($random(seed));
            end
            run_one(s, ref_fir(s), 0, 0);
        end

        test_name = "output back-pressure";
        s = sample_t'($random(seed));
        for (int k = 0; k < 20; k++) begin
            next_s = sample_t'($random(seed));
            stall  = {$random(seed)} % 11;
            send_sample(s, ref_fir(s), 0);
            if (k < 19) begin
                i_din       = next_s; // Offered early, held off by the pending output
                i_din_valid = 1'b1;
            end
            take_output(stall);
            s = next_s;
        end

        test_name = "input gaps";
        for (int k = 0; k < 20; k++) begin
            s   = sample_t'($random(seed));
            gap = {$random(seed)} % 6;
            run_one(s, ref_fir(s), gap, 0);
        end

        repeat (4) @(posedge i_clk);
        check_value("output count", acc_t'(accepted_cnt), acc_t'(output_cnt));
        check_value("pending outputs", '0, acc_t'(exp_q.size()));

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- fir_filter.f
common/fir_cfg_pkg.sv
common/fir_ctrl_pkg.sv
rtl/fir_sequencer.sv
fir_segment/fir_segment.sv
rtl/fir_output_stage.sv
rtl/fir_filter.sv
verification/tb_fir_filter.sv

//--- Makefile
TOOL     = verilator
TOP      = tb_fir_filter
FILELIST = fir_filter.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- weights.mem
// Tap weights, 16-bit two's complement hex, tap 0 first
0001
0004
FFF8
0020
0100
7FFF
8000
0ABC
F123
0007
FFFF
1234
EDCB
0042
8001
0003
